/* logic/mult_pkg.sv */
package mult_pkg;

   // widths of the tags and of the operand words on the CDB
   localparam int TAG_W  = 6;
   localparam int WORD_W = 32;

   // tag 0 stands for an operand that has no producer
   // the CDB never carries it, so a capture can never match it by accident
   typedef logic [TAG_W-1:0] tag_t;

   // operands and results share one width since only the low half of a
   // product is kept
   typedef logic [WORD_W-1:0] word_t;

   // default size of the cluster
   // the top level passes its own values down to every block
   localparam int DEF_NUM_QUEUES  = 4;
   localparam int DEF_QUEUE_DEPTH = 4;

   // the null producer tag, shared by the router, the queues and the bench
   localparam tag_t NULL_TAG = '0;

endpackage

/* logic/queue_entry_if.sv */
`timescale 1ns/1ps

// one dispatched instruction on its way from the router into one issue queue
interface queue_entry_if;
   import mult_pkg::*;

   // destination tag and the two source tags
   tag_t  rdtag;
   tag_t  rstag;
   tag_t  rttag;

   // operand values, meaningful only where the matching valid flag is set
   word_t rsdata;
   word_t rtdata;
   logic  rsvalid;
   logic  rtvalid;

   // en is the write strobe and ready is the level that says the queue
   // can take an instruction at the coming edge
   logic  en;
   logic  ready;

   modport router (
      output rdtag, rstag, rttag, rsdata, rtdata, rsvalid, rtvalid, en,
      input  ready
   );

   modport queue (
      input  rdtag, rstag, rttag, rsdata, rtdata, rsvalid, rtvalid, en,
      output ready
   );

endinterface

/* logic/issue_port_if.sv */
`timescale 1ns/1ps

// the issue candidate of one queue as seen by the CDB arbiter
interface issue_port_if;
   import mult_pkg::*;

   // oldest entry whose two operands are both present
   tag_t  rdtag;
   word_t rsdata;
   word_t rtdata;
   logic  ready;

   // one cycle pulse from the arbiter that retires the candidate
   logic  done;

   modport queue (
      output rdtag, rsdata, rtdata, ready,
      input  done
   );

   modport arbiter (
      input  rdtag, rsdata, rtdata, ready,
      output done
   );

endinterface

/* logic/dispatch_router.sv */
`timescale 1ns/1ps

module dispatch_router #(
   parameter int NUM_QUEUES = mult_pkg::DEF_NUM_QUEUES,
   parameter int QSEL_W     = $clog2(mult_pkg::DEF_NUM_QUEUES)
) (
   input  logic              clk,
   input  logic              arst_n,
   input  logic              dispatch_en,
   input  logic [QSEL_W-1:0] dispatch_queue,
   input  mult_pkg::tag_t    dispatch_rdtag,
   input  mult_pkg::tag_t    dispatch_rstag,
   input  mult_pkg::tag_t    dispatch_rttag,
   input  mult_pkg::word_t   dispatch_rsdata,
   input  mult_pkg::word_t   dispatch_rtdata,
   input  logic              dispatch_rsvalid,
   input  logic              dispatch_rtvalid,
   output logic              dispatch_ready,
   input  logic              cdb_valid,
   input  mult_pkg::tag_t    cdb_tag,
   input  mult_pkg::word_t   cdb_data,
   queue_entry_if.router     entry [NUM_QUEUES-1:0]
);
   import mult_pkg::*;

   logic                  rs_hit;
   logic                  rt_hit;
   word_t                 rsdata;
   word_t                 rtdata;
   logic                  rsvalid;
   logic                  rtvalid;
   logic [NUM_QUEUES-1:0] q_ready;

   // the queues only snoop the CDB for entries they already hold
   // a source whose producer broadcasts in the dispatch cycle itself is caught here
   assign rs_hit = cdb_valid && !dispatch_rsvalid && (cdb_tag == dispatch_rstag);
   assign rt_hit = cdb_valid && !dispatch_rtvalid && (cdb_tag == dispatch_rttag);

   assign rsdata  = rs_hit ? cdb_data : dispatch_rsdata;
   assign rtdata  = rt_hit ? cdb_data : dispatch_rtdata;
   assign rsvalid = dispatch_rsvalid | rs_hit;
   assign rtvalid = dispatch_rtvalid | rt_hit;

   for (genvar g = 0; g < NUM_QUEUES; g++) begin : g_fanout
      // payload goes to every queue and only the addressed one sees en
      assign entry[g].en      = dispatch_en && (dispatch_queue == QSEL_W'(g));
      assign entry[g].rdtag   = dispatch_rdtag;
      assign entry[g].rstag   = dispatch_rstag;
      assign entry[g].rttag   = dispatch_rttag;
      assign entry[g].rsdata  = rsdata;
      assign entry[g].rtdata  = rtdata;
      assign entry[g].rsvalid = rsvalid;
      assign entry[g].rtvalid = rtvalid;
      assign q_ready[g]       = entry[g].ready;
   end

   // ready follows the addressed queue whether or not en is raised
   assign dispatch_ready = q_ready[dispatch_queue];

   // an out of range queue number would drop the instruction silently
   assert property (@(posedge clk) disable iff (!arst_n)
      dispatch_en |-> (int'(dispatch_queue) < NUM_QUEUES));

endmodule

/* logic/issue_queue.sv */
`timescale 1ns/1ps

module issue_queue #(
   parameter int QUEUE_DEPTH = mult_pkg::DEF_QUEUE_DEPTH
) (
   input  logic            clk,
   input  logic            arst_n,
   input  logic            cdb_valid,
   input  mult_pkg::tag_t  cdb_tag,
   input  mult_pkg::word_t cdb_data,
   queue_entry_if.queue    entry,
   issue_port_if.queue     issue
);
   import mult_pkg::*;

   // stored slots, slot 0 holds the oldest instruction
   logic [QUEUE_DEPTH-1:0] q_valid;
   logic [QUEUE_DEPTH-1:0] q_rsvalid;
   logic [QUEUE_DEPTH-1:0] q_rtvalid;
   tag_t                   q_rdtag  [QUEUE_DEPTH];
   tag_t                   q_rstag  [QUEUE_DEPTH];
   tag_t                   q_rttag  [QUEUE_DEPTH];
   word_t                  q_rsdata [QUEUE_DEPTH];
   word_t                  q_rtdata [QUEUE_DEPTH];

   // slots after CDB capture, with the incoming instruction as an extra top slot
   // that has no flops behind it
   logic [QUEUE_DEPTH:0]   w_valid;
   logic [QUEUE_DEPTH:0]   w_rsvalid;
   logic [QUEUE_DEPTH:0]   w_rtvalid;
   tag_t                   w_rdtag  [QUEUE_DEPTH+1];
   tag_t                   w_rstag  [QUEUE_DEPTH+1];
   tag_t                   w_rttag  [QUEUE_DEPTH+1];
   word_t                  w_rsdata [QUEUE_DEPTH+1];
   word_t                  w_rtdata [QUEUE_DEPTH+1];

   logic [QUEUE_DEPTH-1:0] rs_hit;
   logic [QUEUE_DEPTH-1:0] rt_hit;
   logic [QUEUE_DEPTH-1:0] cand;
   logic [QUEUE_DEPTH-1:0] sel;
   logic [QUEUE_DEPTH-1:0] rm;
   logic [QUEUE_DEPTH-1:0] gap;
   logic [QUEUE_DEPTH-1:0] shift;
   logic [QUEUE_DEPTH-1:0] nxt_valid;

   // CDB wakeup on stored entries only
   // the router already did the same for the incoming one
   always_comb begin
      for (int i = 0; i < QUEUE_DEPTH; i++) begin
         rs_hit[i]    = cdb_valid && !q_rsvalid[i] && (cdb_tag == q_rstag[i]);
         rt_hit[i]    = cdb_valid && !q_rtvalid[i] && (cdb_tag == q_rttag[i]);
         w_valid[i]   = q_valid[i];
         w_rsvalid[i] = q_rsvalid[i] | rs_hit[i];
         w_rtvalid[i] = q_rtvalid[i] | rt_hit[i];
         w_rdtag[i]   = q_rdtag[i];
         w_rstag[i]   = q_rstag[i];
         w_rttag[i]   = q_rttag[i];
         w_rsdata[i]  = rs_hit[i] ? cdb_data : q_rsdata[i];
         w_rtdata[i]  = rt_hit[i] ? cdb_data : q_rtdata[i];
      end
      w_valid[QUEUE_DEPTH]   = entry.en && entry.ready;
      w_rsvalid[QUEUE_DEPTH] = entry.rsvalid;
      w_rtvalid[QUEUE_DEPTH] = entry.rtvalid;
      w_rdtag[QUEUE_DEPTH]   = entry.rdtag;
      w_rstag[QUEUE_DEPTH]   = entry.rstag;
      w_rttag[QUEUE_DEPTH]   = entry.rttag;
      w_rsdata[QUEUE_DEPTH]  = entry.rsdata;
      w_rtdata[QUEUE_DEPTH]  = entry.rtdata;
   end

   // candidates are judged on the registered flags
   // so an entry woken this cycle competes from the next one on
   assign cand = q_valid & q_rsvalid & q_rtvalid;

   // isolate the lowest set bit, which is the oldest ready entry
   assign sel  = cand & (~cand + 1'b1);
   assign rm   = issue.done ? sel : '0;

   assign issue.ready = |cand;

   always_comb begin
      // slot 0 is shown when nothing is ready
      issue.rdtag  = q_rdtag[0];
      issue.rsdata = q_rsdata[0];
      issue.rtdata = q_rtdata[0];
      for (int i = 1; i < QUEUE_DEPTH; i++) begin
         if (sel[i]) begin
            issue.rdtag  = q_rdtag[i];
            issue.rsdata = q_rsdata[i];
            issue.rtdata = q_rtdata[i];
         end
      end
   end

   // gap[i] is set when some slot at or below i is empty or being retired
   // every surviving entry above such a slot moves one place down
   always_comb begin
      gap[0] = !q_valid[0] || rm[0];
      for (int i = 1; i < QUEUE_DEPTH; i++) begin
         gap[i] = gap[i-1] || !q_valid[i] || rm[i];
      end
      for (int i = 0; i < QUEUE_DEPTH; i++) begin
         if (i == QUEUE_DEPTH - 1) begin
            shift[i] = w_valid[i+1] && gap[i];
         end else begin
            shift[i] = w_valid[i+1] && !rm[i+1] && gap[i];
         end
      end
      // an entry stays put unless it retires or drops into the slot below
      nxt_valid[0] = shift[0] || (q_valid[0] && !rm[0]);
      for (int i = 1; i < QUEUE_DEPTH; i++) begin
         nxt_valid[i] = shift[i] || (q_valid[i] && !rm[i] && !shift[i-1]);
      end
   end

   // full and not draining is the only case where the top slot cannot move down
   assign entry.ready = gap[QUEUE_DEPTH-1];

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         q_valid   <= '0;
         q_rsvalid <= '0;
         q_rtvalid <= '0;
      end else begin
         q_valid <= nxt_valid;
         for (int i = 0; i < QUEUE_DEPTH; i++) begin
            q_rsvalid[i] <= shift[i] ? w_rsvalid[i+1] : w_rsvalid[i];
            q_rtvalid[i] <= shift[i] ? w_rtvalid[i+1] : w_rtvalid[i];
         end
      end
   end

   always_ff @(posedge clk) begin
      for (int i = 0; i < QUEUE_DEPTH; i++) begin
         q_rdtag[i]  <= shift[i] ? w_rdtag[i+1]  : w_rdtag[i];
         q_rstag[i]  <= shift[i] ? w_rstag[i+1]  : w_rstag[i];
         q_rttag[i]  <= shift[i] ? w_rttag[i+1]  : w_rttag[i];
         q_rsdata[i] <= shift[i] ? w_rsdata[i+1] : w_rsdata[i];
         q_rtdata[i] <= shift[i] ? w_rtdata[i+1] : w_rtdata[i];
      end
   end

   // the arbiter may only retire an entry that this queue is offering
   assert property (@(posedge clk) disable iff (!arst_n)
      issue.done |-> issue.ready);

   // the fill level grows only by an accepted instruction and shrinks only on done
   // so a refused instruction takes no slot and the collapse loses no entry
   assert property (@(posedge clk) disable iff (!arst_n)
      $countones(q_valid) == $countones($past(q_valid))
         + int'($past(entry.en && entry.ready)) - int'($past(issue.done)));

endmodule

/* logic/cdb_arbiter.sv */
`timescale 1ns/1ps

module cdb_arbiter #(
   parameter int NUM_QUEUES = mult_pkg::DEF_NUM_QUEUES,
   parameter int QSEL_W     = $clog2(mult_pkg::DEF_NUM_QUEUES)
) (
   input  logic            clk,
   input  logic            arst_n,
   output logic            cdb_valid,
   output mult_pkg::tag_t  cdb_tag,
   output mult_pkg::word_t cdb_data,
   issue_port_if.arbiter   issue [NUM_QUEUES-1:0]
);
   import mult_pkg::*;

   logic [NUM_QUEUES-1:0] q_ready;
   logic [NUM_QUEUES-1:0] done_vec;
   tag_t                  q_rdtag  [NUM_QUEUES];
   word_t                 q_rsdata [NUM_QUEUES];
   word_t                 q_rtdata [NUM_QUEUES];
   logic [QSEL_W-1:0]     ptr;
   logic [QSEL_W-1:0]     next_ptr;
   logic [QSEL_W-1:0]     grant_idx;
   logic                  grant_valid;
   word_t                 product;

   for (genvar g = 0; g < NUM_QUEUES; g++) begin : g_ports
      assign q_ready[g]    = issue[g].ready;
      assign q_rdtag[g]    = issue[g].rdtag;
      assign q_rsdata[g]   = issue[g].rsdata;
      assign q_rtdata[g]   = issue[g].rtdata;
      assign done_vec[g]   = grant_valid && (grant_idx == QSEL_W'(g));
      assign issue[g].done = done_vec[g];
   end

   // walk the queues from the farthest offset back to the pointer
   // so the last match is the first ready queue at or after it
   always_comb begin
      int idx;
      grant_valid = 1'b0;
      grant_idx   = '0;
      for (int k = NUM_QUEUES - 1; k >= 0; k--) begin
         idx = (int'(ptr) + k) % NUM_QUEUES;
         if (q_ready[idx]) begin
            grant_valid = 1'b1;
            grant_idx   = QSEL_W'(idx);
         end
      end
   end

   // the winner gets the lowest priority next round
   assign next_ptr = (int'(grant_idx) == NUM_QUEUES - 1) ? '0 : grant_idx + 1'b1;

   // a word_t wide context keeps only the low 32 bits of the product
   assign product = q_rsdata[grant_idx] * q_rtdata[grant_idx];

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         cdb_valid <= 1'b0;
         ptr       <= '0;
      end else begin
         cdb_valid <= grant_valid;
         if (grant_valid) begin
            ptr <= next_ptr;
         end
      end
   end

   // the result goes out one cycle after the grant
   always_ff @(posedge clk) begin
      if (grant_valid) begin
         cdb_tag  <= q_rdtag[grant_idx];
         cdb_data <= product;
      end
   end

   // two queues retiring at once would lose one of the results on the single CDB
   assert property (@(posedge clk) disable iff (!arst_n) $onehot0(done_vec));

endmodule

/* logic/mult_cluster.sv */
`timescale 1ns/1ps

module mult_cluster #(
   parameter  int NUM_QUEUES  = mult_pkg::DEF_NUM_QUEUES,
   parameter  int QUEUE_DEPTH = mult_pkg::DEF_QUEUE_DEPTH,
   localparam int QSEL_W      = (NUM_QUEUES > 1) ? $clog2(NUM_QUEUES) : 1
) (
   input  logic              clk,
   input  logic              arst_n,
   input  logic              dispatch_en,
   input  logic [QSEL_W-1:0] dispatch_queue,
   input  mult_pkg::tag_t    dispatch_rdtag,
   input  mult_pkg::tag_t    dispatch_rstag,
   input  mult_pkg::tag_t    dispatch_rttag,
   input  mult_pkg::word_t   dispatch_rsdata,
   input  mult_pkg::word_t   dispatch_rtdata,
   input  logic              dispatch_rsvalid,
   input  logic              dispatch_rtvalid,
   output logic              dispatch_ready,
   output logic              cdb_valid,
   output mult_pkg::tag_t    cdb_tag,
   output mult_pkg::word_t   cdb_data
);

   // one entry link and one issue link per queue
   queue_entry_if entry_bus [NUM_QUEUES-1:0] ();
   issue_port_if  issue_bus [NUM_QUEUES-1:0] ();

   dispatch_router #(
      .NUM_QUEUES (NUM_QUEUES),
      .QSEL_W     (QSEL_W)
   ) u_router (
      .clk              (clk),
      .arst_n           (arst_n),
      .dispatch_en      (dispatch_en),
      .dispatch_queue   (dispatch_queue),
      .dispatch_rdtag   (dispatch_rdtag),
      .dispatch_rstag   (dispatch_rstag),
      .dispatch_rttag   (dispatch_rttag),
      .dispatch_rsdata  (dispatch_rsdata),
      .dispatch_rtdata  (dispatch_rtdata),
      .dispatch_rsvalid (dispatch_rsvalid),
      .dispatch_rtvalid (dispatch_rtvalid),
      .dispatch_ready   (dispatch_ready),
      .cdb_valid        (cdb_valid),
      .cdb_tag          (cdb_tag),
      .cdb_data         (cdb_data),
      .entry            (entry_bus)
   );

   // the CDB fans back into every queue for wakeup
   for (genvar g = 0; g < NUM_QUEUES; g++) begin : g_queue
      issue_queue #(
         .QUEUE_DEPTH (QUEUE_DEPTH)
      ) u_queue (
         .clk       (clk),
         .arst_n    (arst_n),
         .cdb_valid (cdb_valid),
         .cdb_tag   (cdb_tag),
         .cdb_data  (cdb_data),
         .entry     (entry_bus[g]),
         .issue     (issue_bus[g])
      );
   end

   cdb_arbiter #(
      .NUM_QUEUES (NUM_QUEUES),
      .QSEL_W     (QSEL_W)
   ) u_arbiter (
      .clk       (clk),
      .arst_n    (arst_n),
      .cdb_valid (cdb_valid),
      .cdb_tag   (cdb_tag),
      .cdb_data  (cdb_data),
      .issue     (issue_bus)
   );

endmodule

/* bench/mult_cluster_model.svh */
`ifndef MULT_CLUSTER_MODEL_SVH
`define MULT_CLUSTER_MODEL_SVH

// one record per tag, live from acceptance until the tag shows up on the CDB
localparam int NUM_TAGS = 1 << TAG_W;

bit    busy      [NUM_TAGS];
bit    rs_known  [NUM_TAGS];
bit    rt_known  [NUM_TAGS];
tag_t  rs_wait   [NUM_TAGS];
tag_t  rt_wait   [NUM_TAGS];
word_t rs_val    [NUM_TAGS];
word_t rt_val    [NUM_TAGS];
word_t result    [NUM_TAGS];
int    owner_q   [NUM_TAGS];
int    seq_of    [NUM_TAGS];
// first cycle in which the entry may be granted
int    ready_cyc [NUM_TAGS];
int    n_busy;
int    n_bcast;
int    n_capture;

// number of entries that sit in queue q during the current cycle
function automatic int queue_fill(input int q);
   int n;
   n = 0;
   for (int t = 1; t < NUM_TAGS; t++) begin
      if (busy[t] && owner_q[t] == q) begin
         n++;
      end
   end
   return n;
endfunction

// record an instruction accepted in cycle c
task automatic add_entry(input tag_t rd, input int q, input int seq,
                         input logic rsv, input tag_t rst, input word_t rsd,
                         input logic rtv, input tag_t rtt, input word_t rtd, input int c);
   // a missing source whose producer is no longer outstanding was broadcast in
   // this very cycle, so the router must have taken it off the CDB
   rs_known[rd] = rsv || !busy[rst];
   rt_known[rd] = rtv || !busy[rtt];
   rs_val[rd]   = rsv ? rsd : result[rst];
   rt_val[rd]   = rtv ? rtd : result[rtt];
   if (!rsv && !busy[rst]) begin
      n_capture++;
   end
   if (!rtv && !busy[rtt]) begin
      n_capture++;
   end
   rs_wait[rd]   = rst;
   rt_wait[rd]   = rtt;
   owner_q[rd]   = q;
   seq_of[rd]    = seq;
   ready_cyc[rd] = (rs_known[rd] && rt_known[rd]) ? c + 1 : 0;
   busy[rd]      = 1'b1;
   n_busy++;
endtask

// a CDB broadcast seen in cycle c, which was granted in cycle c-1
task automatic retire_tag(input tag_t tag, input word_t data, input int c);
   word_t expected;
   bit    was_ready;
   check(busy[tag], 1'b1, $sformatf("tag %0d broadcast while not outstanding", tag));
   if (busy[tag]) begin
      was_ready = rs_known[tag] && rt_known[tag] && ready_cyc[tag] <= c - 1;
      check(was_ready, 1'b1, $sformatf("tag %0d granted before its operands", tag));
      expected = rs_val[tag] * rt_val[tag];
      check(data, expected, $sformatf("product broadcast for tag %0d", tag));
      // an older entry of the same queue that was eligible at the grant must win
      for (int u = 1; u < NUM_TAGS; u++) begin
         if (busy[u] && u != tag && owner_q[u] == owner_q[tag] && seq_of[u] < seq_of[tag]
             && rs_known[u] && rt_known[u] && ready_cyc[u] <= c - 1) begin
            check(1'b0, 1'b1, $sformatf("tag %0d issued ahead of older tag %0d", tag, u));
         end
      end
      busy[tag] = 1'b0;
      n_busy--;
      n_bcast++;
   end
   result[tag] = data;
   // wake the waiting consumers, which compete from the next cycle on
   for (int u = 1; u < NUM_TAGS; u++) begin
      if (busy[u]) begin
         was_ready = rs_known[u] && rt_known[u];
         if (!rs_known[u] && rs_wait[u] == tag) begin
            rs_known[u] = 1'b1;
            rs_val[u]   = data;
         end
         if (!rt_known[u] && rt_wait[u] == tag) begin
            rt_known[u] = 1'b1;
            rt_val[u]   = data;
         end
         if (!was_ready && rs_known[u] && rt_known[u]) begin
            ready_cyc[u] = c + 1;
         end
      end
   end
endtask

`endif

/* bench/mult_cluster_tb.sv */
`timescale 1ns/1ps

module mult_cluster_tb;
   import mult_pkg::*;

   localparam int NUM_QUEUES  = DEF_NUM_QUEUES;
   localparam int QUEUE_DEPTH = DEF_QUEUE_DEPTH;
   localparam int QSEL_W      = $clog2(NUM_QUEUES);
   localparam int NUM_INSTR   = 400;
   // the first instructions form one dependency chain in queue 0 so that it fills
   localparam int CHAIN_LEN   = 24;
   localparam int MARGIN      = 200;

   logic              clk;
   logic              arst_n;
   logic              dispatch_en;
   logic [QSEL_W-1:0] dispatch_queue;
   tag_t              dispatch_rdtag;
   tag_t              dispatch_rstag;
   tag_t              dispatch_rttag;
   word_t             dispatch_rsdata;
   word_t             dispatch_rtdata;
   logic              dispatch_rsvalid;
   logic              dispatch_rtvalid;
   logic              dispatch_ready;
   logic              cdb_valid;
   tag_t              cdb_tag;
   word_t             cdb_data;

   // the instruction the outside holds until the cluster takes it
   tag_t  h_rd;
   tag_t  h_rs;
   tag_t  h_rt;
   word_t h_rsd;
   word_t h_rtd;
   logic  h_rsv;
   logic  h_rtv;
   int    h_q;
   bit    pending;
   tag_t  last_rd;
   int    accepted;
   int    cyc;
   int    full_cycles;
   int    errors;

   mult_cluster #(
      .NUM_QUEUES  (NUM_QUEUES),
      .QUEUE_DEPTH (QUEUE_DEPTH)
   ) dut0 (
      .clk              (clk),
      .arst_n           (arst_n),
      .dispatch_en      (dispatch_en),
      .dispatch_queue   (dispatch_queue),
      .dispatch_rdtag   (dispatch_rdtag),
      .dispatch_rstag   (dispatch_rstag),
      .dispatch_rttag   (dispatch_rttag),
      .dispatch_rsdata  (dispatch_rsdata),
      .dispatch_rtdata  (dispatch_rtdata),
      .dispatch_rsvalid (dispatch_rsvalid),
      .dispatch_rtvalid (dispatch_rtvalid),
      .dispatch_ready   (dispatch_ready),
      .cdb_valid        (cdb_valid),
      .cdb_tag          (cdb_tag),
      .cdb_data         (cdb_data)
   );

   task automatic check(input logic [31:0] actual, input logic [31:0] expected,
                        input string msg);
      if (actual !== expected) begin
         errors++;
         $display("FAILED at %0t: %s (got %0h, expected %0h)", $time, msg, actual, expected);
      end
   endtask

   `include "mult_cluster_model.svh"

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   // every instruction should be through well inside 20 cycles on average
   initial begin
      repeat (NUM_INSTR * 20 + MARGIN) @(posedge clk);
      $display("watchdog expired with %0d of %0d instructions broadcast", n_bcast, NUM_INSTR);
      $display(">>> FAIL");
      $finish;
   end

   function automatic tag_t pick_busy();
      tag_t t;
      t = tag_t'($urandom_range(NUM_TAGS - 1, 1));
      while (!busy[t]) begin
         t = tag_t'($urandom_range(NUM_TAGS - 1, 1));
      end
      return t;
   endfunction

   task automatic make_instr(input int idx);
      h_rd = tag_t'($urandom_range(NUM_TAGS - 1, 1));
      while (busy[h_rd]) begin
         h_rd = tag_t'($urandom_range(NUM_TAGS - 1, 1));
      end
      // tag 0 with the valid flag set stands for a plain value
      h_rsv = 1'b1;
      h_rtv = 1'b1;
      h_rs  = NULL_TAG;
      h_rt  = NULL_TAG;
      h_rsd = $urandom();
      h_rtd = $urandom();
      if (idx < CHAIN_LEN) begin
         h_q = 0;
         if (idx > 0 && busy[last_rd]) begin
            h_rsv = 1'b0;
            h_rs  = last_rd;
         end
      end else begin
         h_q = $urandom_range(NUM_QUEUES - 1, 0);
         if (n_busy > 0 && $urandom_range(2, 0) == 0) begin
            h_rsv = 1'b0;
            h_rs  = pick_busy();
         end
         if (n_busy > 0 && $urandom_range(2, 0) == 0) begin
            h_rtv = 1'b0;
            h_rt  = pick_busy();
         end
      end
   endtask

   task automatic drive_held();
      dispatch_en      <= 1'b1;
      dispatch_queue   <= QSEL_W'(h_q);
      dispatch_rdtag   <= h_rd;
      dispatch_rstag   <= h_rs;
      dispatch_rttag   <= h_rt;
      dispatch_rsdata  <= h_rsd;
      dispatch_rtdata  <= h_rtd;
      dispatch_rsvalid <= h_rsv;
      dispatch_rtvalid <= h_rtv;
   endtask

   // called mid cycle where the CDB and the ready level are settled
   task automatic observe();
      if (cdb_valid) begin
         retire_tag(cdb_tag, cdb_data, cyc);
      end
      if (pending) begin
         if (queue_fill(h_q) < QUEUE_DEPTH) begin
            check(dispatch_ready, 1'b1, $sformatf("queue %0d with a free slot refused", h_q));
         end
         if (!dispatch_ready) begin
            full_cycles++;
         end else begin
            add_entry(h_rd, h_q, accepted, h_rsv, h_rs, h_rsd, h_rtv, h_rt, h_rtd, cyc);
            last_rd = h_rd;
            accepted++;
            pending = 1'b0;
         end
      end
   endtask

   initial begin
      void'($urandom(32'h6644_0abe));
      arst_n           = 1'b0;
      dispatch_en      = 1'b0;
      dispatch_queue   = '0;
      dispatch_rdtag   = NULL_TAG;
      dispatch_rstag   = NULL_TAG;
      dispatch_rttag   = NULL_TAG;
      dispatch_rsdata  = '0;
      dispatch_rtdata  = '0;
      dispatch_rsvalid = 1'b0;
      dispatch_rtvalid = 1'b0;
      repeat (8) @(posedge clk);
      arst_n <= 1'b1;
      @(negedge clk);
      check(cdb_valid, 1'b0, "cdb_valid high after reset");
      check(dispatch_ready, 1'b1, "dispatch_ready low after reset");
      while (pending || accepted < NUM_INSTR || n_busy > 0) begin
         @(posedge clk);
         cyc++;
         if (!pending && accepted < NUM_INSTR) begin
            make_instr(accepted);
            pending = 1'b1;
         end else if (pending) begin
            // a held instruction picks up results broadcast while it waited
            if (!h_rsv && !busy[h_rs]) begin
               h_rsv = 1'b1;
               h_rsd = result[h_rs];
            end
            if (!h_rtv && !busy[h_rt]) begin
               h_rtv = 1'b1;
               h_rtd = result[h_rt];
            end
         end
         if (pending) begin
            drive_held();
         end else begin
            dispatch_en <= 1'b0;
         end
         @(negedge clk);
         observe();
      end
      check(n_bcast, NUM_INSTR, "number of broadcasts");
      check(n_busy, 0, "tags still outstanding at the end");
      check(full_cycles != 0, 1'b1, "dispatch_ready never dropped for a full queue");
      check(n_capture != 0, 1'b1, "no operand was taken off the CDB in its dispatch cycle");
      $display("errors %0d, instructions %0d, broadcasts %0d, same cycle captures %0d, full %0d",
               errors, accepted, n_bcast, n_capture, full_cycles);
      if (errors == 0) begin
         $display(">>> PASS");
      end else begin
         $display(">>> FAIL");
      end
      $finish;
   end

endmodule

/* mult_cluster.f */
+incdir+bench
logic/mult_pkg.sv
logic/queue_entry_if.sv
logic/issue_port_if.sv
logic/dispatch_router.sv
logic/issue_queue.sv
logic/cdb_arbiter.sv
logic/mult_cluster.sv
bench/mult_cluster_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# compile the multiply cluster testbench with verilator, run it and scan the log

cd "$(dirname "$0")" || exit 1
mkdir -p obj_dir

verilator --binary --timing --assert -Wno-fatal --top-module mult_cluster_tb \
   -f mult_cluster.f -Mdir obj_dir -o mult_cluster_sim \
   && ./obj_dir/mult_cluster_sim | tee sim.log \
   || { echo "compile or simulation step failed"; exit 1; }

grep -qx ">>> PASS" sim.log && echo "simulation passed" \
   || { echo "simulation failed"; exit 1; }
